/* hdl/l2_defines.svh */
`ifndef L2_DEFINES_SVH
`define L2_DEFINES_SVH

`define L2_CORES        4

// core word address = tag | index | offset
`define L2_ADDR_W       14
`define L2_TAG_W        3
`define L2_INDEX_W      9
`define L2_OFFSET_W     2

`define L2_SETS         512
`define L2_WORDS        4   // words per line

`define L2_WORD_W       32
`define L2_LINE_W       128

// memory is addressed by line, tag and index only
`define L2_MEM_ADDR_W   12

`endif

/* hdl/l2_pkg.sv */
`include "l2_defines.svh"

package l2_pkg;

    typedef struct packed
    {
        logic [`L2_TAG_W-1:0]    tag;
        logic [`L2_INDEX_W-1:0]  index;
        logic [`L2_OFFSET_W-1:0] offset;
    } core_addr_t;

    typedef logic [$clog2(`L2_CORES)-1:0] core_id_t;

    // flat to and from memory, by word for merges
    typedef union packed
    {
        logic [`L2_LINE_W-1:0]                flat;
        logic [`L2_WORDS-1:0][`L2_WORD_W-1:0] words;
    } line_t;

endpackage

/* hdl/l2_arbiter.sv */
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_arbiter
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`L2_CORES-1:0]  req,
    input  logic                  take,
    output l2_pkg::core_id_t      grant_id
);
    import l2_pkg::*;

    core_id_t pick;
    core_id_t cand;
    logic     found;

    // search starts one past the last grant
    always_comb
    begin
        pick  = grant_id;
        found = 1'b0;
        cand  = grant_id;
        for (int i = 1; i <= `L2_CORES; i++)
        begin
            cand = core_id_t'(grant_id + i);
            if (!found && req[cand])
            begin
                pick  = cand;
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            grant_id <= core_id_t'(`L2_CORES - 1);  // core 0 wins first
        else if (take)
            grant_id <= pick;
    end

endmodule

/* hdl/l2_tag_store.sv */
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_tag_store
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`L2_INDEX_W-1:0] rd_index,
    input  logic                   rd_en,
    output logic [`L2_TAG_W-1:0]   rd_tag,
    output logic                   rd_valid,
    output logic                   rd_dirty,
    input  logic                   wr_en,
    input  logic [`L2_INDEX_W-1:0] wr_index,
    input  logic [`L2_TAG_W-1:0]   wr_tag,
    input  logic                   wr_dirty
);

    logic [`L2_TAG_W-1:0] tag_mem [`L2_SETS];
    logic [`L2_SETS-1:0]  valid_bits;
    logic [`L2_SETS-1:0]  dirty_bits;

    always_ff @(posedge clk)
    begin
        if (rd_en)
            rd_tag <= tag_mem[rd_index];
        if (wr_en)
            tag_mem[wr_index] <= wr_tag;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_bits <= '0;
            dirty_bits <= '0;
            rd_valid   <= 1'b0;
            rd_dirty   <= 1'b0;
        end
        else
        begin
            if (rd_en)
            begin
                rd_valid <= valid_bits[rd_index];
                rd_dirty <= dirty_bits[rd_index];
            end
            if (wr_en)
            begin
                valid_bits[wr_index] <= 1'b1;   // any update installs the set
                dirty_bits[wr_index] <= wr_dirty;
            end
        end
    end

endmodule

/* hdl/l2_data_store.sv */
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_data_store
(
    input  logic                   clk,
    input  logic                   en,
    input  logic [`L2_WORDS-1:0]   wr_mask,
    input  logic [`L2_INDEX_W-1:0] index,
    input  l2_pkg::line_t          wdata,
    output l2_pkg::line_t          rdata
);

    // one word-wide array per word lane
    logic [`L2_WORD_W-1:0] word_mem [`L2_WORDS][`L2_SETS];

    always_ff @(posedge clk)
    begin
        if (en)
        begin
            for (int w = 0; w < `L2_WORDS; w++)
            begin
                if (wr_mask[w])
                    word_mem[w][index] <= wdata.words[w];
                else
                    rdata.words[w] <= word_mem[w][index];  // held while en is low
            end
        end
    end

endmodule

/* hdl/l2_controller.sv */
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_controller
(
    input  logic                                 clk,
    input  logic                                 rst,

    input  logic [`L2_CORES-1:0]                 core_rd_wr,
    input  l2_pkg::core_addr_t [`L2_CORES-1:0]   core_addr,
    input  logic [`L2_CORES-1:0][`L2_WORD_W-1:0] core_wdata,
    output logic [`L2_CORES-1:0]                 core_page_wr,
    output l2_pkg::line_t                        core_page_din,
    output logic [`L2_CORES-1:0]                 core_wr_ack,
    output logic [`L2_CORES-1:0]                 core_c_dirty,
    output l2_pkg::core_addr_t                   core_c_dirty_addr,

    output logic                                 mem_valid,
    output logic                                 mem_rd_wr,
    output logic [`L2_MEM_ADDR_W-1:0]            mem_addr,
    output l2_pkg::line_t                        mem_din,
    input  l2_pkg::line_t                        mem_dout,
    input  logic                                 mem_ack,

    output logic                                 arb_take,
    input  l2_pkg::core_id_t                     grant_id,
    input  logic                                 any_req,

    output logic [`L2_INDEX_W-1:0]               tag_rd_index,
    output logic                                 tag_rd_en,
    input  logic [`L2_TAG_W-1:0]                 tag_rd_tag,
    input  logic                                 tag_rd_valid,
    input  logic                                 tag_rd_dirty,
    output logic                                 tag_wr_en,
    output logic [`L2_INDEX_W-1:0]               tag_wr_index,
    output logic [`L2_TAG_W-1:0]                 tag_wr_tag,
    output logic                                 tag_wr_dirty,

    output logic                                 ds_en,
    output logic [`L2_WORDS-1:0]                 ds_wr_mask,
    output logic [`L2_INDEX_W-1:0]               ds_index,
    output l2_pkg::line_t                        ds_wdata,
    input  l2_pkg::line_t                        ds_rdata
);
    import l2_pkg::*;

    typedef enum logic [2:0]
    {
        S_IDLE,
        S_GRANT,
        S_LOOKUP,
        S_COMPARE,
        S_WRITEBACK,
        S_REFILL,
        S_INSTALL,
        S_RESPOND
    } state_t;

    state_t                state;
    core_addr_t            req_addr;
    core_id_t              req_id;
    logic                  req_wr;
    logic [`L2_WORD_W-1:0] req_wdata;
    logic                  miss_q;
    line_t                 fill_q;
    line_t                 merged;
    logic                  hit;
    logic                  resp_pending;

    assign arb_take = (state == S_GRANT);

    assign tag_rd_en    = (state == S_LOOKUP);
    assign tag_rd_index = core_addr[grant_id].index;

    assign hit = tag_rd_valid && (tag_rd_tag == req_addr.tag);

    // install after refill, or word write on a write hit
    assign tag_wr_en    = (state == S_INSTALL) || (state == S_RESPOND && req_wr && !miss_q);
    assign tag_wr_index = req_addr.index;
    assign tag_wr_tag   = req_addr.tag;
    assign tag_wr_dirty = req_wr;

    // refilled line with the write word laid over it
    always_comb
    begin
        merged = fill_q;
        if (req_wr)
            merged.words[req_addr.offset] = req_wdata;
    end

    assign ds_en      = (state == S_COMPARE) || tag_wr_en;
    assign ds_index   = req_addr.index;
    assign ds_wdata   = merged;
    assign ds_wr_mask = (state == S_INSTALL) ? {`L2_WORDS{1'b1}} :
                        (state == S_RESPOND) ? `L2_WORDS'(1) << req_addr.offset :
                                               '0;

    // victim line read in compare stays on rdata through writeback
    assign mem_din = ds_rdata;

    // requester still holds valid while its pulse is out
    assign resp_pending = |core_page_wr || |core_wr_ack;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state        <= S_IDLE;
            miss_q       <= 1'b0;
            mem_valid    <= 1'b0;
            mem_rd_wr    <= 1'b0;
            core_page_wr <= '0;
            core_wr_ack  <= '0;
            core_c_dirty <= '0;
        end
        else
        begin
            core_page_wr <= '0;
            core_wr_ack  <= '0;
            core_c_dirty <= '0;
            case (state)
                S_IDLE:
                    if (any_req && !resp_pending)
                        state <= S_GRANT;
                S_GRANT:
                    state <= S_LOOKUP;
                S_LOOKUP:
                    state <= S_COMPARE;
                S_COMPARE:
                begin
                    miss_q <= !hit;
                    if (hit)
                        state <= S_RESPOND;
                    else if (tag_rd_valid && tag_rd_dirty)
                    begin
                        mem_valid <= 1'b1;
                        mem_rd_wr <= 1'b1;
                        state     <= S_WRITEBACK;
                    end
                    else
                    begin
                        mem_valid <= 1'b1;
                        mem_rd_wr <= 1'b0;
                        state     <= S_REFILL;
                    end
                end
                S_WRITEBACK:
                    if (mem_ack)
                    begin
                        mem_valid <= 1'b0;
                        state     <= S_REFILL;
                    end
                S_REFILL:
                    if (!mem_valid)
                    begin
                        mem_valid <= 1'b1;  // read goes out a cycle after writeback ack
                        mem_rd_wr <= 1'b0;
                    end
                    else if (mem_ack)
                    begin
                        mem_valid <= 1'b0;
                        state     <= S_INSTALL;
                    end
                S_INSTALL:
                    state <= S_RESPOND;
                S_RESPOND:
                begin
                    core_page_wr[req_id] <= !req_wr;
                    core_wr_ack[req_id]  <= req_wr;
                    if (req_wr)
                        core_c_dirty <= ~(`L2_CORES'(1) << req_id);  // all but the writer
                    state <= S_IDLE;
                end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == S_LOOKUP)
        begin
            req_addr  <= core_addr[grant_id];
            req_id    <= grant_id;
            req_wr    <= core_rd_wr[grant_id];
            req_wdata <= core_wdata[grant_id];
        end
        if (state == S_COMPARE && !hit)
        begin
            if (tag_rd_valid && tag_rd_dirty)
                mem_addr <= {tag_rd_tag, req_addr.index};   // victim line
            else
                mem_addr <= {req_addr.tag, req_addr.index};
        end
        if (state == S_WRITEBACK && mem_ack)
            mem_addr <= {req_addr.tag, req_addr.index};
        if (state == S_REFILL && mem_valid && mem_ack)
            fill_q <= mem_dout;
        if (state == S_RESPOND)
        begin
            core_page_din     <= miss_q ? fill_q : ds_rdata;
            core_c_dirty_addr <= req_addr;
        end
    end

endmodule

/* hdl/l2_cache_top.sv */
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_cache_top
(
    input  logic                                 clk,
    input  logic                                 rst,

    input  logic [`L2_CORES-1:0]                 core_valid,
    input  logic [`L2_CORES-1:0]                 core_rd_wr,
    input  l2_pkg::core_addr_t [`L2_CORES-1:0]   core_addr,
    input  logic [`L2_CORES-1:0][`L2_WORD_W-1:0] core_wdata,
    output logic [`L2_CORES-1:0]                 core_page_wr,
    output l2_pkg::line_t                        core_page_din,
    output logic [`L2_CORES-1:0]                 core_wr_ack,
    output logic [`L2_CORES-1:0]                 core_c_dirty,
    output l2_pkg::core_addr_t                   core_c_dirty_addr,

    output logic                                 mem_valid,
    output logic                                 mem_rd_wr,
    output logic [`L2_MEM_ADDR_W-1:0]            mem_addr,
    output l2_pkg::line_t                        mem_din,
    input  l2_pkg::line_t                        mem_dout,
    input  logic                                 mem_ack
);
    import l2_pkg::*;

    logic                   arb_take;
    core_id_t               grant_id;

    logic [`L2_INDEX_W-1:0] tag_rd_index;
    logic                   tag_rd_en;
    logic [`L2_TAG_W-1:0]   tag_rd_tag;
    logic                   tag_rd_valid;
    logic                   tag_rd_dirty;
    logic                   tag_wr_en;
    logic [`L2_INDEX_W-1:0] tag_wr_index;
    logic [`L2_TAG_W-1:0]   tag_wr_tag;
    logic                   tag_wr_dirty;

    logic                   ds_en;
    logic [`L2_WORDS-1:0]   ds_wr_mask;
    logic [`L2_INDEX_W-1:0] ds_index;
    line_t                  ds_wdata;
    line_t                  ds_rdata;

    l2_arbiter u_arbiter
    (
        .clk      (clk),
        .rst      (rst),
        .req      (core_valid),
        .take     (arb_take),
        .grant_id (grant_id)
    );

    l2_tag_store u_tag_store
    (
        .clk      (clk),
        .rst      (rst),
        .rd_index (tag_rd_index),
        .rd_en    (tag_rd_en),
        .rd_tag   (tag_rd_tag),
        .rd_valid (tag_rd_valid),
        .rd_dirty (tag_rd_dirty),
        .wr_en    (tag_wr_en),
        .wr_index (tag_wr_index),
        .wr_tag   (tag_wr_tag),
        .wr_dirty (tag_wr_dirty)
    );

    l2_data_store u_data_store
    (
        .clk     (clk),
        .en      (ds_en),
        .wr_mask (ds_wr_mask),
        .index   (ds_index),
        .wdata   (ds_wdata),
        .rdata   (ds_rdata)
    );

    l2_controller u_controller
    (
        .clk               (clk),
        .rst               (rst),
        .core_rd_wr        (core_rd_wr),
        .core_addr         (core_addr),
        .core_wdata        (core_wdata),
        .core_page_wr      (core_page_wr),
        .core_page_din     (core_page_din),
        .core_wr_ack       (core_wr_ack),
        .core_c_dirty      (core_c_dirty),
        .core_c_dirty_addr (core_c_dirty_addr),
        .mem_valid         (mem_valid),
        .mem_rd_wr         (mem_rd_wr),
        .mem_addr          (mem_addr),
        .mem_din           (mem_din),
        .mem_dout          (mem_dout),
        .mem_ack           (mem_ack),
        .arb_take          (arb_take),
        .grant_id          (grant_id),
        .any_req           (|core_valid),
        .tag_rd_index      (tag_rd_index),
        .tag_rd_en         (tag_rd_en),
        .tag_rd_tag        (tag_rd_tag),
        .tag_rd_valid      (tag_rd_valid),
        .tag_rd_dirty      (tag_rd_dirty),
        .tag_wr_en         (tag_wr_en),
        .tag_wr_index      (tag_wr_index),
        .tag_wr_tag        (tag_wr_tag),
        .tag_wr_dirty      (tag_wr_dirty),
        .ds_en             (ds_en),
        .ds_wr_mask        (ds_wr_mask),
        .ds_index          (ds_index),
        .ds_wdata          (ds_wdata),
        .ds_rdata          (ds_rdata)
    );

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen
#(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 8
)
(
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD_NS / 2) clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (RST_CYCLES)
            @(posedge clk);
        @(negedge clk);
        rst = 1'b0;     // released on a falling edge like every other input
    end

endmodule

/* dv/tb_mem_model.sv */
`timescale 1ns/1ps
`include "l2_defines.svh"

module tb_mem_model
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      mem_valid,
    input  logic                      mem_rd_wr,
    input  logic [`L2_MEM_ADDR_W-1:0] mem_addr,
    input  l2_pkg::line_t             mem_din,
    output l2_pkg::line_t             mem_dout,
    output logic                      mem_ack
);
    import l2_pkg::*;

    line_t       lines [1 << `L2_MEM_ADDR_W];
    int unsigned rd_count;
    int unsigned wr_count;
    int unsigned lcg_state;
    int unsigned delay;

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;     // low bits of an lcg cycle too fast
    endfunction

    initial
    begin
        lcg_state = 8567;
        rd_count  = 0;
        wr_count  = 0;
        mem_ack   = 1'b0;
        mem_dout  = '0;
        for (int l = 0; l < (1 << `L2_MEM_ADDR_W); l++)
            for (int w = 0; w < `L2_WORDS; w++)
                lines[l].words[w] = 32'hA500_0000 | (l * `L2_WORDS + w);
        forever
        begin
            @(negedge clk);
            if (!rst && mem_valid)
            begin
                delay = lcg_next() % 4 + 1;     // ack after 1 to 4 cycles
                repeat (delay - 1)
                    @(negedge clk);
                if (mem_rd_wr)
                begin
                    lines[mem_addr] = mem_din;
                    wr_count++;
                end
                else
                begin
                    mem_dout = lines[mem_addr];
                    rd_count++;
                end
                mem_ack = 1'b1;
                @(negedge clk);
                mem_ack = 1'b0;
            end
        end
    end

endmodule

/* dv/l2_cache_tb.sv */
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_cache_tb;
    import l2_pkg::*;

    logic                                 clk;
    logic                                 rst;
    logic [`L2_CORES-1:0]                 core_valid;
    logic [`L2_CORES-1:0]                 core_rd_wr;
    core_addr_t [`L2_CORES-1:0]           core_addr;
    logic [`L2_CORES-1:0][`L2_WORD_W-1:0] core_wdata;
    logic [`L2_CORES-1:0]                 core_page_wr;
    line_t                                core_page_din;
    logic [`L2_CORES-1:0]                 core_wr_ack;
    logic [`L2_CORES-1:0]                 core_c_dirty;
    core_addr_t                           core_c_dirty_addr;
    logic                                 mem_valid;
    logic                                 mem_rd_wr;
    logic [`L2_MEM_ADDR_W-1:0]            mem_addr;
    line_t                                mem_din;
    line_t                                mem_dout;
    logic                                 mem_ack;

    // reference images of every line and of the cache state
    line_t                     ref_img [1 << `L2_MEM_ADDR_W];
    logic [`L2_TAG_W-1:0]      ref_tag [`L2_SETS];
    logic [`L2_SETS-1:0]       ref_valid;
    logic [`L2_SETS-1:0]       ref_dirty;
    core_id_t                  last_core;

    logic [`L2_CORES-1:0]      exp_page_wr;
    logic [`L2_CORES-1:0]      exp_wr_ack;
    line_t                     exp_line;
    core_addr_t                exp_addr;
    logic                      exp_miss;
    logic                      exp_wb;
    logic [`L2_MEM_ADDR_W-1:0] exp_wb_addr;
    logic [`L2_MEM_ADDR_W-1:0] exp_rd_addr;
    line_t                     exp_wb_line;
    int unsigned               exp_rd_total;
    int unsigned               exp_wr_total;

    int                        cyc;
    int                        issued;
    logic                      started;

    tb_clock_gen #(.PERIOD_NS(8), .RST_CYCLES(8)) clk0
    (
        .clk (clk),
        .rst (rst)
    );

    tb_mem_model mem0
    (
        .clk       (clk),
        .rst       (rst),
        .mem_valid (mem_valid),
        .mem_rd_wr (mem_rd_wr),
        .mem_addr  (mem_addr),
        .mem_din   (mem_din),
        .mem_dout  (mem_dout),
        .mem_ack   (mem_ack)
    );

    l2_cache_top dut0
    (
        .clk               (clk),
        .rst               (rst),
        .core_valid        (core_valid),
        .core_rd_wr        (core_rd_wr),
        .core_addr         (core_addr),
        .core_wdata        (core_wdata),
        .core_page_wr      (core_page_wr),
        .core_page_din     (core_page_din),
        .core_wr_ack       (core_wr_ack),
        .core_c_dirty      (core_c_dirty),
        .core_c_dirty_addr (core_c_dirty_addr),
        .mem_valid         (mem_valid),
        .mem_rd_wr         (mem_rd_wr),
        .mem_addr          (mem_addr),
        .mem_din           (mem_din),
        .mem_dout          (mem_dout),
        .mem_ack           (mem_ack)
    );

    always @(posedge clk)
        cyc <= cyc + 1;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] act);
        abort_run($sformatf("CHECK FAILED %s expected %0h actual %0h", name, exp, act));
    endtask

    a_quiet: assert property (@(posedge clk) disable iff (rst)
        !started |-> ((core_page_wr | core_wr_ack | core_c_dirty) == '0 && !mem_valid))
    else
        report_mismatch("reset quiet", 0, {$sampled(core_page_wr), $sampled(core_wr_ack),
                                           $sampled(core_c_dirty), $sampled(mem_valid)});

    a_page_target: assert property (@(posedge clk) disable iff (rst)
        core_page_wr != '0 |-> core_page_wr == exp_page_wr)
    else
        report_mismatch("page_wr target", exp_page_wr, $sampled(core_page_wr));

    a_page_data: assert property (@(posedge clk) disable iff (rst)
        core_page_wr != '0 |-> core_page_din == exp_line)
    else
        report_mismatch("page data", exp_line, $sampled(core_page_din));

    // ack to the writer and the notice to everyone else in one cycle
    a_ack_notice: assert property (@(posedge clk) disable iff (rst)
        (core_wr_ack | core_c_dirty) != '0 |->
            (core_wr_ack == exp_wr_ack && core_c_dirty == ~exp_wr_ack))
    else
        report_mismatch("wr_ack and c_dirty", {exp_wr_ack, ~exp_wr_ack},
                        {$sampled(core_wr_ack), $sampled(core_c_dirty)});

    a_notice_addr: assert property (@(posedge clk) disable iff (rst)
        core_wr_ack != '0 |-> core_c_dirty_addr == exp_addr)
    else
        report_mismatch("c_dirty_addr", exp_addr, $sampled(core_c_dirty_addr));

    a_mem_wb: assert property (@(posedge clk) disable iff (rst)
        (mem_valid && mem_ack && mem_rd_wr) |-> (exp_wb && mem_addr == exp_wb_addr))
    else
        report_mismatch("writeback flag and address", {exp_wb, exp_wb_addr},
                        {1'b1, $sampled(mem_addr)});

    a_mem_wb_data: assert property (@(posedge clk) disable iff (rst)
        (mem_valid && mem_ack && mem_rd_wr) |-> mem_din == exp_wb_line)
    else
        report_mismatch("writeback data", exp_wb_line, $sampled(mem_din));

    a_mem_rd: assert property (@(posedge clk) disable iff (rst)
        (mem_valid && mem_ack && !mem_rd_wr) |-> (exp_miss && mem_addr == exp_rd_addr))
    else
        report_mismatch("refill flag and address", {exp_miss, exp_rd_addr},
                        {1'b1, $sampled(mem_addr)});

    task automatic raise(input int c, input bit wr, input int tag, input int index,
                         input int offset, input logic [`L2_WORD_W-1:0] wdata);
        core_rd_wr[c]       = wr;
        core_addr[c].tag    = tag[`L2_TAG_W-1:0];
        core_addr[c].index  = index[`L2_INDEX_W-1:0];
        core_addr[c].offset = offset[`L2_OFFSET_W-1:0];
        core_wdata[c]       = wdata;
        core_valid[c]       = 1'b1;
        issued++;
        started = 1'b1;
    endtask

    // predict the next core served, wait for its pulse, then release it
    task automatic serve_next(input int t0, input bit timed);
        core_id_t                  c;
        core_addr_t                a;
        logic [`L2_MEM_ADDR_W-1:0] line_a;
        bit                        hit;
        c = core_id_t'(last_core + 1);
        while (!core_valid[c])
            c = core_id_t'(c + 1);
        a           = core_addr[c];
        line_a      = {a.tag, a.index};
        hit         = ref_valid[a.index] && ref_tag[a.index] == a.tag;
        exp_miss    = !hit;
        exp_wb      = !hit && ref_valid[a.index] && ref_dirty[a.index];
        exp_wb_addr = {ref_tag[a.index], a.index};
        exp_wb_line = ref_img[exp_wb_addr];
        exp_rd_addr = line_a;
        exp_rd_total += exp_miss;
        exp_wr_total += exp_wb;
        if (core_rd_wr[c])
            ref_img[line_a].words[a.offset] = core_wdata[c];
        exp_line    = ref_img[line_a];
        exp_addr    = a;
        exp_page_wr = core_rd_wr[c] ? '0 : `L2_CORES'(1) << c;
        exp_wr_ack  = core_rd_wr[c] ? `L2_CORES'(1) << c : '0;
        ref_dirty[a.index] = (hit && ref_dirty[a.index]) || core_rd_wr[c];
        ref_valid[a.index] = 1'b1;
        ref_tag[a.index]   = a.tag;
        last_core = c;
        while ((core_page_wr | core_wr_ack) == '0)
            @(negedge clk);
        core_valid[c] = 1'b0;
        if (timed && hit)
        begin
            assert (cyc - t0 == 4)
            else
                report_mismatch("hit latency", 4, cyc - t0);
        end
        assert (mem0.rd_count == exp_rd_total)
        else
            report_mismatch("memory read count", exp_rd_total, mem0.rd_count);
        assert (mem0.wr_count == exp_wr_total)
        else
            report_mismatch("memory write count", exp_wr_total, mem0.wr_count);
        if (exp_wb)
        begin
            assert (mem0.lines[exp_wb_addr] == ref_img[exp_wb_addr])
            else
                report_mismatch("memory image", ref_img[exp_wb_addr], mem0.lines[exp_wb_addr]);
        end
        @(negedge clk);     // pulse checked on the edge before this one
    endtask

    task automatic single(input int c, input bit wr, input int tag, input int index,
                          input int offset, input logic [`L2_WORD_W-1:0] wdata);
        int t0;
        @(negedge clk);
        raise(c, wr, tag, index, offset, wdata);
        t0 = cyc + 1;   // request sampled at the next edge
        serve_next(t0, 1'b1);
    endtask

    initial
    begin
        core_valid   = '0;
        core_rd_wr   = '0;
        core_addr    = '0;
        core_wdata   = '0;
        started      = 1'b0;
        last_core    = core_id_t'(`L2_CORES - 1);
        exp_page_wr  = '0;
        exp_wr_ack   = '0;
        exp_line     = '0;
        exp_addr     = '0;
        exp_miss     = 1'b0;
        exp_wb       = 1'b0;
        exp_wb_addr  = '0;
        exp_rd_addr  = '0;
        exp_wb_line  = '0;
        exp_rd_total = 0;
        exp_wr_total = 0;
        ref_valid    = '0;
        ref_dirty    = '0;
        for (int s = 0; s < `L2_SETS; s++)
            ref_tag[s] = '0;
        for (int l = 0; l < (1 << `L2_MEM_ADDR_W); l++)
            for (int w = 0; w < `L2_WORDS; w++)
                ref_img[l].words[w] = 32'hA500_0000 | (l * `L2_WORDS + w);

        wait (rst === 1'b0);
        repeat (4)
            @(negedge clk);     // idle outputs stay low here

        // all four at once, served 0 to 3
        @(negedge clk);
        raise(0, 1'b0, 0, 10, 0, '0);
        raise(1, 1'b1, 0, 11, 2, 32'h0BAD_F00D);
        raise(2, 1'b0, 0, 12, 1, '0);
        raise(3, 1'b0, 1, 13, 3, '0);
        repeat (4)
            serve_next(0, 1'b0);

        // core 2 served, then 0 wins over 2
        single(2, 1'b0, 0, 12, 0, '0);
        @(negedge clk);
        raise(2, 1'b0, 0, 11, 1, '0);
        raise(0, 1'b0, 0, 10, 3, '0);
        repeat (2)
            serve_next(0, 1'b0);

        single(1, 1'b0, 2, 100, 1, '0);     // cold miss
        single(3, 1'b0, 2, 100, 0, '0);
        single(2, 1'b1, 2, 100, 3, 32'hDEAD_BEEF);
        single(0, 1'b0, 2, 100, 0, '0);
        single(1, 1'b0, 5, 100, 2, '0);     // dirty victim goes back first
        single(0, 1'b0, 6, 100, 0, '0);     // clean victim dropped
        single(3, 1'b1, 1, 200, 1, 32'h1234_5678);
        single(2, 1'b0, 4, 200, 0, '0);
        single(2, 1'b0, 1, 200, 0, '0);

        repeat (4)
            @(negedge clk);
        $display("test passed");
        $finish;
    end

    // budget grows with every request issued
    initial
    begin
        while (cyc <= 20 + 200 * issued)
            @(posedge clk);
        abort_run("timeout: the DUT stopped responding within 200 cycles per request");
    end

endmodule

/* sim.f */
+incdir+hdl
hdl/l2_pkg.sv
hdl/l2_arbiter.sv
hdl/l2_tag_store.sv
hdl/l2_data_store.sv
hdl/l2_controller.sv
hdl/l2_cache_top.sv
dv/tb_clock_gen.sv
dv/tb_mem_model.sv
dv/l2_cache_tb.sv
